//--- files.f
common/board_pkg.sv
common/audio_pkg.sv
common/sample_if.sv
hw/mic/inmp441_mic_i2s_receiver.sv
hw/keys/key_debouncer.sv
hw/meter/seven_seg_mux.sv
hw/meter/level_meter.sv
hw/board_specific_top.sv
dv/tb_clock_gen.sv
dv/tb_board_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps --top-module tb_board_top \
    -f files.f -o sim_tb &&
./obj_dir/sim_tb || { echo "simulation failed"; exit 1; }

//--- dv/tb_board_top.sv
`timescale 1ns/100ps

module tb_board_top;

    import board_pkg::*;
    import audio_pkg::*;

    localparam int sck_div         = 2;
    localparam int debounce_cycles = 4;
    localparam int scan_cycles     = 2;
    localparam int credit_depth    = 2;
    localparam int n_frames        = 33;
    localparam int watchdog_cycles = (n_frames + 10) * 64 * 2 * sck_div;

    logic               clk;
    logic               arst_n;
    logic [w_key-1:0]   key;
    logic [w_led-1:0]   led;
    logic [7:0]         abcdefgh;
    logic [w_digit-1:0] digit;
    logic               mic_sck;
    logic               mic_ws;
    logic               mic_lr;
    logic               mic_sd;

    // microphone model state
    sample_t     sample_q [$];
    logic [31:0] rng;
    sample_t     word;
    int          fall_idx;
    int          frame_no;
    logic        prev_sck;
    logic        prev_ws;

    // expected meter state
    magnitude_t exp_peak;
    magnitude_t exp_cur;
    logic       exp_hold;
    logic       exp_show_cur;
    logic       exp_ovr;
    magnitude_t pend [$];

    tb_clock_gen i_clock
    (
        .clk    ( clk    ),
        .arst_n ( arst_n )
    );

    board_specific_top
    #(
        .sck_div         ( sck_div         ),
        .debounce_cycles ( debounce_cycles ),
        .scan_cycles     ( scan_cycles     ),
        .credit_depth    ( credit_depth    )
    )
    dut0
    (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .key      ( key      ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_lr   ( mic_lr   ),
        .mic_sd   ( mic_sd   )
    );

    //--------------------------------------------------
    // reference functions

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic magnitude_t ref_magnitude(input sample_t s);
        if (s == 24'h800000)
            return 24'h7fffff;  // most negative value saturates
        else if (s[23])
            return magnitude_t'(~s + 24'd1);
        else
            return magnitude_t'(s);
    endfunction

    function automatic seg_t ref_seg(input logic [3:0] n);
        case (n)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    function automatic led_t ref_leds(input magnitude_t v, input logic ovr);
        led_t l;
        for (int i = 0; i < w_led - 1; i++)
            l[i] = (v >= (24'd1 << (18 + i)));
        l[w_led-1] = ovr;
        return l;
    endfunction

    //--------------------------------------------------
    // failure reporting and compare tasks

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_seg(input int idx, input seg_t got, input seg_t exp);
        if (got !== exp)
            report_mismatch($sformatf("digit %0d segments %b, expected %b", idx, got, exp));
    endtask

    task automatic check_leds(input led_t got, input led_t exp);
        if (got !== exp)
            report_mismatch($sformatf("leds %b, expected %b", got, exp));
    endtask

    task automatic check_mic_lr(input logic got);
        if (got !== 1'b0)
            report_mismatch($sformatf("mic_lr %b, expected 0 for the left slot", got));
    endtask

    //--------------------------------------------------
    // model of the meter

    task automatic apply_sample(input magnitude_t m);
        exp_cur = m;
        if (m > exp_peak)
            exp_peak = m;
    endtask

    task automatic accept_sample(input magnitude_t m);
        if (!exp_hold)
            apply_sample(m);
        else if (pend.size() < credit_depth)
            pend.push_back(m);  // waits in the FIFO
        else
            exp_ovr = 1'b1;     // no credit left, dropped
    endtask

    task automatic apply_key(input int idx);
        case (idx)
            0:
            begin
                exp_peak = '0;
                exp_ovr  = 1'b0;
            end
            1:
            begin
                exp_hold = !exp_hold;
                while (!exp_hold && pend.size() != 0)
                    apply_sample(pend.pop_front());
            end
            default:
                exp_show_cur = !exp_show_cur;
        endcase
    endtask

    //--------------------------------------------------
    // display scan and frame sequencing

    task automatic check_display();
        magnitude_t         v;
        logic [w_digit-1:0] seen;
        int                 idx;
        int                 n;
        v    = exp_show_cur ? exp_cur : exp_peak;
        seen = '0;
        n    = 0;
        while (seen != '1)
        begin
            @(posedge clk);
            n++;
            if (n > 8 * w_digit * scan_cycles)
                abort_run("The display scan did not reach every digit.");
            if (!$onehot(digit))
                abort_run("The digit enable is not one-hot during the scan.");
            idx = 0;
            for (int i = 0; i < w_digit; i++)
                if (digit[i])
                    idx = i;
            seen[idx] = 1'b1;
            check_seg(idx, abcdefgh, ref_seg(v[4 * idx +: 4]));
        end
        check_leds(led_t'(~led), ref_leds(v, exp_ovr));
        check_mic_lr(mic_lr);
    endtask

    task automatic next_frame();
        sample_t s;
        while (sample_q.size() == 0)
            @(posedge clk);
        while (mic_ws == 1'b0)  // left slot still running
            @(posedge clk);
        repeat (8) @(posedge clk);
        s = sample_q.pop_front();
        accept_sample(ref_magnitude(s));
        check_display();
    endtask

    task automatic press_key(input int idx);
        @(posedge clk);
        key <= ~(w_key'(1) << idx);
        repeat (20) @(posedge clk);
        key <= '1;
        repeat (20) @(posedge clk);
        apply_key(idx);
        check_display();
    endtask

    //--------------------------------------------------
    // microphone model, sd changes after each sck fall

    always @(posedge clk)
    begin
        if (prev_sck && !mic_sck)
        begin
            if (prev_ws && !mic_ws)  // left slot starts
            begin
                rng = xorshift32(rng);
                if (frame_no == 18)
                    word = 24'h7fffff;
                else if (frame_no == 19)
                    word = 24'h800000;
                else
                    word = rng[23:0];
                sample_q.push_back(word);
                frame_no++;
                fall_idx = 0;
            end
            else
                fall_idx++;
            if (fall_idx >= 1 && fall_idx <= w_sample)
                mic_sd <= word[w_sample - fall_idx];
            else
                mic_sd <= 1'b0;
        end
        prev_sck = mic_sck;
        prev_ws  = mic_ws;
    end

    //--------------------------------------------------
    // watchdog

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("The run timed out before all tests finished.");
        $display("Test failures found");
        $fatal(1);
    end

    //--------------------------------------------------
    // main sequence

    initial
    begin
        key          = '1;
        mic_sd       = 1'b0;
        rng          = 32'hce02;
        word         = '0;
        fall_idx     = 100;
        frame_no     = 0;
        prev_sck     = 1'b0;
        prev_ws      = 1'b0;
        exp_peak     = '0;
        exp_cur      = '0;
        exp_hold     = 1'b0;
        exp_show_cur = 1'b0;
        exp_ovr      = 1'b0;

        wait (arst_n === 1'b1);
        repeat (4) @(posedge clk);
        check_leds(led_t'(~led), '0);  // nothing lit before the first frame
        check_display();

        repeat (20) next_frame();       // peak mode, running maximum

        press_key(0);                   // clear
        repeat (2) next_frame();

        press_key(2);                   // show current
        repeat (3) next_frame();
        press_key(2);                   // back to peak
        next_frame();

        press_key(1);                   // hold
        repeat (4) next_frame();
        press_key(1);                   // release hold, queued samples drain
        repeat (2) next_frame();
        press_key(0);
        next_frame();

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
    output logic clk,
    output logic arst_n
);

    localparam int half_period = 20;  // 40 ns clock
    localparam int reset_len   = 16;

    initial
    begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (reset_len) @(posedge clk);
        arst_n <= 1'b1;
    end

    always #(half_period) clk = ~clk;

endmodule

//--- hw/board_specific_top.sv
`timescale 1ns/100ps

module board_specific_top
#(
    parameter int clk_mhz         = 27,
    parameter int sck_div         = (clk_mhz + 5) / 6,  // sck near 2.7 MHz
    parameter int debounce_cycles = clk_mhz * 10000,    // about 10 ms
    parameter int scan_cycles     = clk_mhz * 1000,     // about 1 ms per digit
    parameter int credit_depth    = 4
)
(
    input  logic                          clk,
    input  logic                          arst_n,

    input  logic [board_pkg::w_key-1:0]   key,  // active low
    output logic [board_pkg::w_led-1:0]   led,  // active low

    output logic [7:0]                    abcdefgh,
    output logic [board_pkg::w_digit-1:0] digit,

    output logic                          mic_sck,
    output logic                          mic_ws,
    output logic                          mic_lr,
    input  logic                          mic_sd
);

    import board_pkg::*;

    logic    clear_overrun;
    logic    key_valid;
    key_op_t key_op;
    led_t    top_led;

    sample_if smp ();

    assign mic_lr = 1'b0;  // left slot
    assign led    = ~top_led;

    //--------------------------------------------------

    inmp441_mic_i2s_receiver
    #(
        .sck_div      ( sck_div      ),
        .credit_depth ( credit_depth )
    )
    i_microphone
    (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .sck           ( mic_sck       ),
        .ws            ( mic_ws        ),
        .sd            ( mic_sd        ),
        .clear_overrun ( clear_overrun ),
        .smp           ( smp.source    )
    );

    key_debouncer
    #(
        .debounce_cycles ( debounce_cycles )
    )
    i_keys
    (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .key_n     ( key       ),
        .key_valid ( key_valid ),
        .key_op    ( key_op    )
    );

    level_meter
    #(
        .credit_depth ( credit_depth ),
        .scan_cycles  ( scan_cycles  )
    )
    i_meter
    (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .smp           ( smp.sink      ),
        .key_valid     ( key_valid     ),
        .key_op        ( key_op        ),
        .clear_overrun ( clear_overrun ),
        .led           ( top_led       ),
        .abcdefgh      ( abcdefgh      ),
        .digit         ( digit         )
    );

endmodule

//--- hw/meter/level_meter.sv
`timescale 1ns/100ps

module level_meter
#(
    parameter int credit_depth = 4,
    parameter int scan_cycles  = 1000
)
(
    input  logic               clk,
    input  logic               arst_n,
    sample_if.sink             smp,
    input  logic               key_valid,
    input  board_pkg::key_op_t key_op,
    output logic               clear_overrun,
    output board_pkg::led_t    led,
    output board_pkg::seg_t    abcdefgh,
    output board_pkg::digit_t  digit
);

    import board_pkg::*;
    import audio_pkg::*;

    localparam int w_ptr    = (credit_depth > 1) ? $clog2(credit_depth) : 1;
    localparam int w_fill   = $clog2(credit_depth + 1);
    localparam int bar_base = 18;  // led[0] threshold is 2^18

    sample_t          mem [credit_depth];
    logic [w_ptr-1:0] wr_ptr;
    logic [w_ptr-1:0] rd_ptr;
    logic [w_fill-1:0] fill;
    logic             pop;
    logic             hold;
    logic             show_current;
    logic             overrun_q;
    logic             cmd_clear;
    logic             cmd_hold;
    logic             cmd_mode;
    magnitude_t       head_mag;
    magnitude_t       cur_mag;
    magnitude_t       peak;
    magnitude_t       disp_value;
    logic [w_led-2:0] bar_q;

    function automatic magnitude_t to_magnitude(input sample_t s);
        if (s == sample_t'({1'b1, {(w_sample - 1){1'b0}}}))
            return magnitude_t'({1'b0, {(w_sample - 1){1'b1}}});  // saturate -2^23
        else if (s < 0)
            return magnitude_t'(-s);
        else
            return magnitude_t'(s);
    endfunction

    function automatic logic [w_ptr-1:0] next_ptr(input logic [w_ptr-1:0] p);
        if (p == w_ptr'(credit_depth - 1))
            return '0;
        else
            return p + 1'b1;
    endfunction

    //--------------------------------------------------
    // sample FIFO, sized by the credits

    assign pop            = (fill != '0) && !hold;
    assign smp.credit_ret = pop;

    always_ff @(posedge clk)
    begin
        if (smp.valid)
            mem[wr_ptr] <= smp.sample;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (smp.valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (smp.valid && !pop)
                fill <= fill + 1'b1;
            else if (!smp.valid && pop)
                fill <= fill - 1'b1;
        end
    end

    //--------------------------------------------------
    // commands and levels

    assign cmd_clear     = key_valid && (key_op == op_clear);
    assign cmd_hold      = key_valid && (key_op == op_hold);
    assign cmd_mode      = key_valid && (key_op == op_mode);
    assign clear_overrun = cmd_clear;
    assign head_mag      = to_magnitude(mem[rd_ptr]);
    assign disp_value    = show_current ? cur_mag : peak;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hold         <= 1'b0;
            show_current <= 1'b0;  // peak mode
            overrun_q    <= 1'b0;
            cur_mag      <= '0;
            peak         <= '0;
        end
        else
        begin
            if (cmd_hold)
                hold <= ~hold;
            if (cmd_mode)
                show_current <= ~show_current;
            overrun_q <= smp.overrun_seen && !cmd_clear;
            if (pop)
                cur_mag <= head_mag;
            if (cmd_clear)
                peak <= '0;
            else if (pop && head_mag > peak)
                peak <= head_mag;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            bar_q <= '0;
        else
            for (int i = 0; i < w_led - 1; i++)
                bar_q[i] <= (disp_value >= (magnitude_t'(1) << (bar_base + i)));
    end

    assign led = {overrun_q, bar_q};

    //--------------------------------------------------
    // display

    seven_seg_mux
    #(
        .scan_cycles ( scan_cycles )
    )
    i_seven_seg
    (
        .clk      ( clk        ),
        .arst_n   ( arst_n     ),
        .value    ( disp_value ),
        .abcdefgh ( abcdefgh   ),
        .digit    ( digit      )
    );

endmodule

//--- hw/meter/seven_seg_mux.sv
`timescale 1ns/100ps

module seven_seg_mux
#(
    parameter int scan_cycles = 1000
)
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  audio_pkg::magnitude_t value,
    output board_pkg::seg_t       abcdefgh,
    output board_pkg::digit_t     digit
);

    import board_pkg::*;

    localparam int w_scan = (scan_cycles > 1) ? $clog2(scan_cycles) : 1;
    localparam int w_sel  = $clog2(w_digit);

    logic [w_scan-1:0] scan_cnt;
    logic [w_sel-1:0]  sel;
    logic [3:0]        nibble;

    function automatic seg_t hex_to_seg(input logic [3:0] h);
        case (h)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;  // lower case b
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;  // lower case d
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;  // F
        endcase
    endfunction

    //--------------------------------------------------
    // digit scan

    assign nibble = value[4 * sel +: 4];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            scan_cnt <= '0;
            sel      <= '0;
        end
        else if (scan_cnt == w_scan'(scan_cycles - 1))
        begin
            scan_cnt <= '0;
            sel      <= (sel == w_sel'(w_digit - 1)) ? '0 : sel + 1'b1;
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            digit    <= '0;  // blank until the first scan cycle
            abcdefgh <= '0;
        end
        else
        begin
            digit    <= digit_t'(1) << sel;
            abcdefgh <= hex_to_seg(nibble);
        end
    end

endmodule

//--- hw/keys/key_debouncer.sv
`timescale 1ns/100ps

module key_debouncer
#(
    parameter int debounce_cycles = 4
)
(
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [board_pkg::w_key-1:0]   key_n,
    output logic                          key_valid,
    output board_pkg::key_op_t            key_op
);

    import board_pkg::*;

    localparam int n_used = 3;  // clear, hold, mode
    localparam int w_cnt  = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;

    logic [n_used-1:0] sync_1;
    logic [n_used-1:0] sync_2;
    logic [n_used-1:0] stable;  // debounced pressed state
    logic [w_cnt-1:0]  stab_cnt [n_used];
    logic [n_used-1:0] press;

    //--------------------------------------------------
    // synchronizer, pressed is high

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync_1 <= '0;
            sync_2 <= '0;
        end
        else
        begin
            sync_1 <= ~key_n[n_used-1:0];
            sync_2 <= sync_1;
        end
    end

    //--------------------------------------------------
    // per-key stability counters

    always_comb
    begin
        for (int i = 0; i < n_used; i++)
            press[i] = sync_2[i] && !stable[i]
                       && (stab_cnt[i] == w_cnt'(debounce_cycles - 1));
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            stable <= '0;
            for (int i = 0; i < n_used; i++)
                stab_cnt[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < n_used; i++)
            begin
                if (sync_2[i] == stable[i])
                    stab_cnt[i] <= '0;  // bounce restarts the count
                else if (stab_cnt[i] == w_cnt'(debounce_cycles - 1))
                begin
                    stab_cnt[i] <= '0;
                    stable[i]   <= sync_2[i];
                end
                else
                    stab_cnt[i] <= stab_cnt[i] + 1'b1;
            end
        end
    end

    //--------------------------------------------------
    // command event, lowest key wins

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            key_valid <= 1'b0;
            key_op    <= op_none;
        end
        else
        begin
            key_valid <= |press;
            if (press[0])
                key_op <= op_clear;
            else if (press[1])
                key_op <= op_hold;
            else if (press[2])
                key_op <= op_mode;
            else
                key_op <= op_none;
        end
    end

endmodule

//--- hw/mic/inmp441_mic_i2s_receiver.sv
`timescale 1ns/100ps

module inmp441_mic_i2s_receiver
#(
    parameter int sck_div      = 4,
    parameter int credit_depth = 4
)
(
    input  logic     clk,
    input  logic     arst_n,
    output logic     sck,
    output logic     ws,
    input  logic     sd,
    input  logic     clear_overrun,
    sample_if.source smp
);

    import audio_pkg::*;

    localparam int w_div    = (sck_div > 1) ? $clog2(sck_div) : 1;
    localparam int w_bit    = $clog2(frame_bits);
    localparam int w_shift  = $clog2(w_sample);
    localparam int w_credit = $clog2(credit_depth + 1);

    logic [w_div-1:0]    div_cnt;
    logic [w_bit-1:0]    bit_cnt;
    logic                div_end;
    logic                sck_rise;
    logic                sck_fall;
    logic                half_end;  // ws toggles on this sck fall
    rx_state_t           state;
    logic [w_shift-1:0]  shift_cnt;
    logic [w_sample-1:0] shreg;
    logic [w_credit-1:0] credit_cnt;
    logic                overrun;
    logic                send;

    //--------------------------------------------------
    // sck and ws generation

    assign div_end  = (div_cnt == w_div'(sck_div - 1));
    assign sck_rise = div_end && !sck;
    assign sck_fall = div_end && sck;
    assign half_end = sck_fall && (bit_cnt == w_bit'(frame_bits - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (div_end)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bit_cnt <= '0;
            ws      <= 1'b0;
        end
        else if (half_end)
        begin
            bit_cnt <= '0;
            ws      <= ~ws;
        end
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;
    end

    //--------------------------------------------------
    // left-slot capture

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= st_wait_ws;
            shift_cnt <= '0;
        end
        else
        begin
            case (state)
                st_wait_ws:
                    if (half_end && ws)  // ws about to fall
                        state <= st_skip;
                st_skip:
                    if (sck_rise)
                    begin
                        state     <= st_shift;
                        shift_cnt <= '0;
                    end
                st_shift:
                    if (sck_rise)
                    begin
                        shift_cnt <= shift_cnt + 1'b1;
                        if (shift_cnt == w_shift'(w_sample - 1))
                            state <= st_send;
                    end
                st_send:
                    state <= st_pad;
                st_pad:
                    if (half_end && !ws)  // right slot begins
                        state <= st_wait_ws;
                default:
                    state <= st_wait_ws;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == st_shift && sck_rise)
            shreg <= {shreg[w_sample-2:0], sd};
    end

    //--------------------------------------------------
    // credits and drop flag

    assign send = (state == st_send) && (credit_cnt != '0);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            credit_cnt <= w_credit'(credit_depth);
        else if (send && !smp.credit_ret)
            credit_cnt <= credit_cnt - 1'b1;
        else if (!send && smp.credit_ret)
            credit_cnt <= credit_cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            overrun <= 1'b0;
        else if (state == st_send && credit_cnt == '0)
            overrun <= 1'b1;  // sample dropped
        else if (clear_overrun)
            overrun <= 1'b0;
    end

    assign smp.valid        = send;
    assign smp.sample       = sample_t'(shreg);
    assign smp.overrun_seen = overrun;

endmodule

//--- common/sample_if.sv
`timescale 1ns/100ps

interface sample_if;

    import audio_pkg::*;

    logic    valid;         // one-cycle pulse per sample
    sample_t sample;
    logic    overrun_seen;  // sticky drop flag of the source
    logic    credit_ret;    // one pulse per popped entry

    modport source
    (
        output valid,
        output sample,
        output overrun_seen,
        input  credit_ret
    );

    modport sink
    (
        input  valid,
        input  sample,
        input  overrun_seen,
        output credit_ret
    );

endinterface

//--- common/audio_pkg.sv
package audio_pkg;

    localparam int w_sample   = 24;  // INMP441 data word
    localparam int frame_bits = 32;  // sck periods per ws half-frame

    typedef logic signed [w_sample-1:0] sample_t;
    typedef logic        [w_sample-1:0] magnitude_t;

    //--------------------------------------------------
    // I2S receiver FSM

    typedef enum logic [2:0]
    {
        st_wait_ws,  // waiting for ws to fall
        st_skip,     // one-bit I2S delay
        st_shift,    // MSB first
        st_send,
        st_pad       // rest of the left slot
    } rx_state_t;

endpackage

//--- common/board_pkg.sv
package board_pkg;

    //--------------------------------------------------
    // board I/O widths

    localparam int w_key   = 5;  // keys 0 to 2 carry commands
    localparam int w_led   = 6;
    localparam int w_digit = 6;

    //--------------------------------------------------
    // display and LED vectors

    typedef logic [7:0]         seg_t;    // abcdefgh, h is the decimal point
    typedef logic [w_digit-1:0] digit_t;  // one-hot digit enable
    typedef logic [w_led-1:0]   led_t;

    //--------------------------------------------------
    // key commands

    typedef enum logic [1:0]
    {
        op_none,
        op_clear,  // key 0
        op_hold,   // key 1
        op_mode    // key 2
    } key_op_t;

endpackage
